//--- Bender.yml
package:
  name: rvcore

sources:
  - hdl/rvPkg.sv
  - hdl/rvDecoder.sv
  - hdl/rvRegFile.sv
  - hdl/rvAlu.sv
  - hdl/rvPcUnit.sv
  - hdl/rvWriteback.sv
  - hdl/rvCore.sv
  - target: test
    files:
      - dv/rvCoreTb.sv

//--- dv/rvCoreTb.sv
`timescale 1ns/10ps

module rvCoreTb;

	localparam logic [31:0] nopWord = 32'h0000_0013;

	logic           clk;
	logic           arstN;
	logic           inReset;
	logic [31:0]    inst;
	logic [31:0]    readData;
	logic [31:0]    pc;
	logic [31:0]    dataAddr;
	logic [31:0]    writeData;
	logic           memWrite;
	rvPkg::memSizeE memSize;
	logic           halted;

	logic [31:0] imem [0:511];
	logic [31:0] dmem [0:255];
	logic [31:0] expSlot [0:31];
	logic [31:0] seed;
	int          progPtr;
	int          nExp;

	rvCore dut_i (
		.clk       (clk),
		.arstN     (arstN),
		.inst      (inst),
		.readData  (readData),
		.pc        (pc),
		.dataAddr  (dataAddr),
		.writeData (writeData),
		.memWrite  (memWrite),
		.memSize   (memSize),
		.halted    (halted)
	);

	always #50 clk = ~clk;

	// combinational memories, nop fed while in reset
	assign inst     = inReset ? nopWord : imem[pc[10:2]];
	assign readData = dmem[dataAddr[9:2]];

	function automatic logic [31:0] mergeStore(input logic [31:0] old, input logic [31:0] data,
			input logic [1:0] offs, input rvPkg::memSizeE size);
		logic [31:0] word;
		word = old;
		for (int i = 0; i < 4; i++) begin
			if (size == rvPkg::memWord || (size == rvPkg::memHalf && (i / 2) == offs[1]) ||
					(size == rvPkg::memByte && i == offs)) begin
				word[8*i +: 8] = data[8*i +: 8];
			end
		end
		return word;
	endfunction

	always @(posedge clk) begin
		if (arstN && memWrite) begin
			dmem[dataAddr[9:2]] <= mergeStore(dmem[dataAddr[9:2]], writeData, dataAddr[1:0],
				memSize);
		end
	end

	function automatic logic [31:0] nextRandom();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [31:0] fillWord(input int idx);
		logic [7:0] a;
		a = idx[7:0];
		return {a, ~a, a ^ 8'h5a, 8'hc3};
	endfunction

	// instruction encoders
	function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// ISA reference for OP and OP-IMM
	function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		logic signed [31:0] sa;
		sa = a;
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (alt) begin
					return sa >>> b[4:0];
				end
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	task automatic checkEq(input logic [31:0] got, input logic [31:0] expected, input string what);
		if (got !== expected) begin
			$display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, expected);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic emit(input logic [31:0] word);
		imem[progPtr] = word;
		progPtr++;
	endtask

	// lui + addi, upper part rounded for the signed low part
	task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] upper;
		upper = (value + 32'h800) >> 12;
		emit(uType(upper[19:0], rd, 7'b0110111));
		emit(iType(value[11:0], rd, 3'd0, rd, 7'b0010011));
	endtask

	task automatic storeResult(input logic [4:0] rs, input logic [31:0] value);
		emit(sType(12'(4 * nExp), rs, 5'd0, 3'd2));
		expSlot[nExp] = value;
		nExp++;
	endtask

	task automatic startProgram();
		progPtr = 0;
		nExp    = 0;
		for (int i = 0; i < 512; i++) begin
			imem[i] = rvPkg::ebreakInst;
		end
		for (int i = 0; i < 256; i++) begin
			dmem[i] = fillWord(i);
		end
	endtask

	task automatic resetCore();
		@(posedge clk);
		#1;
		inReset = 1'b1;
		arstN   = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		checkEq(pc, 32'h0000_0000, "pc after reset");
		checkEq(halted, 1'b0, "halted after reset");
		arstN   = 1'b1;
		inReset = 1'b0;
	endtask

	task automatic runProgram();
		int cycles;
		resetCore();
		cycles = 0;
		while (!halted && cycles < 200) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!halted) begin
			$display("core did not halt within 200 cycles at %0t", $time);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic checkResults(input string what);
		for (int k = 0; k < nExp; k++) begin
			checkEq(dmem[k], expSlot[k], $sformatf("%s slot %0d", what, k));
		end
	endtask

	task automatic testArithmetic();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic [11:0] imm;
		startProgram();
		// negative a and a nonzero shift so sra differs from srl
		a = nextRandom() | 32'h8000_0000;
		b = nextRandom() | 32'h0000_0001;
		loadConst(5'd1, a);
		loadConst(5'd2, b);
		for (int f3 = 0; f3 < 8; f3++) begin
			emit(rType(7'h00, 5'd2, 5'd1, 3'(f3), 5'd3));
			storeResult(5'd3, aluModel(3'(f3), 1'b0, a, b));
		end
		emit(rType(7'h20, 5'd2, 5'd1, 3'd0, 5'd3));
		storeResult(5'd3, aluModel(3'd0, 1'b1, a, b));
		emit(rType(7'h20, 5'd2, 5'd1, 3'd5, 5'd3));
		storeResult(5'd3, aluModel(3'd5, 1'b1, a, b));
		for (int f3 = 0; f3 < 9; f3++) begin
			r = nextRandom();
			imm = r[11:0];
			// shifts carry only a shamt, index 8 is srai
			if (f3 == 1 || f3 == 5) begin
				imm = {7'b0, r[4:0] | 5'd1};
			end else if (f3 == 8) begin
				imm = {7'b0100000, r[4:0] | 5'd1};
			end
			emit(iType(imm, 5'd1, 3'(f3 == 8 ? 5 : f3), 5'd3, 7'b0010011));
			storeResult(5'd3, aluModel(3'(f3 == 8 ? 5 : f3), f3 == 8, a, {{20{imm[11]}}, imm}));
		end
		emit(rvPkg::ebreakInst);
		runProgram();
		checkResults("arithmetic");
	endtask

	task automatic testLoads();
		logic [31:0] w;
		logic [7:0]  bt;
		logic [15:0] hw;
		startProgram();
		// bytes 1 and 2 negative, low half negative, high half positive
		w = (nextRandom() & 32'h7f7f_7f7f) | 32'h0080_8000;
		dmem[64] = w;
		for (int o = 0; o < 4; o++) begin
			bt = w[8*o +: 8];
			emit(iType(12'(256 + o), 5'd0, 3'd0, 5'd3, 7'b0000011));
			storeResult(5'd3, {{24{bt[7]}}, bt});
			emit(iType(12'(256 + o), 5'd0, 3'd4, 5'd3, 7'b0000011));
			storeResult(5'd3, {24'b0, bt});
		end
		for (int o = 0; o < 4; o += 2) begin
			hw = w[8*o +: 16];
			emit(iType(12'(256 + o), 5'd0, 3'd1, 5'd3, 7'b0000011));
			storeResult(5'd3, {{16{hw[15]}}, hw});
			emit(iType(12'(256 + o), 5'd0, 3'd5, 5'd3, 7'b0000011));
			storeResult(5'd3, {16'b0, hw});
		end
		emit(iType(12'd256, 5'd0, 3'd2, 5'd3, 7'b0000011));
		storeResult(5'd3, w);
		emit(rvPkg::ebreakInst);
		runProgram();
		checkResults("loads");
	endtask

	task automatic testStores();
		logic [31:0] v;
		logic [31:0] expWord [0:5];
		startProgram();
		v = nextRandom();
		loadConst(5'd1, v);
		for (int o = 0; o < 4; o++) begin
			dmem[80 + o] = nextRandom();
			expWord[o] = dmem[80 + o];
			expWord[o][8*o +: 8] = v[7:0];
			emit(sType(12'(320 + 5 * o), 5'd1, 5'd0, 3'd0));
		end
		for (int k = 0; k < 2; k++) begin
			dmem[84 + k] = nextRandom();
			expWord[4 + k] = dmem[84 + k];
			expWord[4 + k][16*k +: 16] = v[15:0];
			emit(sType(12'(336 + 6 * k), 5'd1, 5'd0, 3'd1));
		end
		emit(rvPkg::ebreakInst);
		runProgram();
		for (int i = 0; i < 6; i++) begin
			checkEq(dmem[80 + i], expWord[i], $sformatf("store word %0d", 80 + i));
		end
	endtask

	task automatic testControlFlow();
		logic [31:0] p;
		logic [31:0] n;
		logic [2:0]  f3;
		logic [4:0]  rsA;
		logic [4:0]  rsB;
		logic [31:0] base;
		startProgram();
		p = nextRandom() & 32'h7fff_ffff;
		n = nextRandom() | 32'h8000_0000;
		loadConst(5'd4, p);
		loadConst(5'd5, n);
		for (int c = 0; c < 6; c++) begin
			f3 = 3'((c < 2) ? c : c + 2);
			for (int k = 0; k < 3; k++) begin
				rsA = (k == 1) ? 5'd5 : 5'd4;
				rsB = (k == 2) ? 5'd5 : 5'd4;
				// marker 1 on the fall-through path, 2 on the taken path
				emit(bType(13'd12, rsB, rsA, f3));
				emit(iType(12'd1, 5'd0, 3'd0, 5'd3, 7'b0010011));
				emit(jType(21'd8, 5'd0));
				emit(iType(12'd2, 5'd0, 3'd0, 5'd3, 7'b0010011));
				storeResult(5'd3, branchTaken(f3, rsA == 5'd5 ? n : p, rsB == 5'd5 ? n : p) ?
					32'd2 : 32'd1);
			end
		end
		base = 4 * progPtr;
		emit(jType(21'd8, 5'd6));
		emit(iType(12'd1, 5'd0, 3'd0, 5'd9, 7'b0010011));
		storeResult(5'd6, base + 4);
		// odd jalr target, auipc at the target reports the real pc
		base = 4 * progPtr;
		loadConst(5'd7, base + 17);
		emit(iType(12'd0, 5'd7, 3'd0, 5'd8, 7'b1100111));
		emit(iType(12'd1, 5'd0, 3'd0, 5'd9, 7'b0010011));
		emit(uType(20'd0, 5'd10, 7'b0010111));
		storeResult(5'd8, base + 12);
		storeResult(5'd10, base + 16);
		storeResult(5'd9, 32'd0);
		emit(rvPkg::ebreakInst);
		runProgram();
		checkResults("control flow");
	endtask

	task automatic testPcRelative();
		logic [31:0] r;
		logic [31:0] addr;
		startProgram();
		r = nextRandom();
		emit(nopWord);
		addr = 4 * progPtr;
		emit(uType(r[19:0], 5'd11, 7'b0010111));
		storeResult(5'd11, addr + {r[19:0], 12'b0});
		emit(iType({1'b0, r[30:20]} | 12'h1, 5'd0, 3'd0, 5'd0, 7'b0010011));
		emit(uType(r[31:12], 5'd0, 7'b0110111));
		storeResult(5'd0, 32'd0);
		emit(rvPkg::ebreakInst);
		runProgram();
		checkResults("auipc and x0");
	endtask

	task automatic testHalt();
		logic [31:0] haltAddr;
		logic [31:0] storeWord;
		startProgram();
		storeWord = sType(12'd160, 5'd1, 5'd0, 3'd2);
		emit(iType(12'h055, 5'd0, 3'd0, 5'd1, 7'b0010011));
		storeResult(5'd1, 32'h55);
		haltAddr = 4 * progPtr;
		emit(rvPkg::ebreakInst);
		emit(storeWord);
		runProgram();
		checkResults("before halt");
		// the halted core now sees the store at its frozen pc
		imem[haltAddr[10:2]] = storeWord;
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			#1;
			checkEq(pc, haltAddr, "pc while halted");
			checkEq(memWrite, 1'b0, "memWrite while halted");
			checkEq(halted, 1'b1, "halted level");
		end
		checkEq(dmem[40], fillWord(40), "store after ebreak");
	endtask

	initial begin
		clk     = 1'b0;
		arstN   = 1'b0;
		inReset = 1'b1;
		seed    = 32'h3d8c_bf8c;
		startProgram();
		testArithmetic();
		testLoads();
		testStores();
		testControlFlow();
		testPcRelative();
		testHalt();
		$display("No errors");
		$finish;
	end

endmodule

//--- hdl/rvAlu.sv
`timescale 1ns/10ps

module rvAlu (
	input  rvPkg::ctrlT ctrl,
	input  logic [31:0] pc,
	input  logic [31:0] rs1Data,
	input  logic [31:0] rs2Data,
	input  logic [31:0] imm,
	output logic [31:0] aluResult
);

	logic [31:0] opA;
	logic [31:0] opB;
	logic [4:0]  shamt;

	// zero operand wins over pc, used by lui
	always_comb begin
		if (ctrl.aluAZero) begin
			opA = '0;
		end else if (ctrl.aluAPc) begin
			opA = pc;
		end else begin
			opA = rs1Data;
		end
	end

	assign opB   = ctrl.aluBImm ? imm : rs2Data;
	assign shamt = opB[4:0];

	always_comb begin
		case (ctrl.aluOp)
			rvPkg::aluAdd:   aluResult = opA + opB;
			rvPkg::aluSub:   aluResult = opA - opB;
			rvPkg::aluSll:   aluResult = opA << shamt;
			rvPkg::aluSlt:   aluResult = {31'b0, $signed(opA) < $signed(opB)};
			rvPkg::aluSltu:  aluResult = {31'b0, opA < opB};
			rvPkg::aluXor:   aluResult = opA ^ opB;
			rvPkg::aluSrl:   aluResult = opA >> shamt;
			rvPkg::aluSra:   aluResult = $unsigned($signed(opA) >>> shamt);
			rvPkg::aluOr:    aluResult = opA | opB;
			rvPkg::aluAnd:   aluResult = opA & opB;
			rvPkg::aluPassB: aluResult = opB;
			default:         aluResult = '0;
		endcase
	end

endmodule

//--- hdl/rvCore.sv
`timescale 1ns/10ps

module rvCore (
	input  logic           clk,
	input  logic           arstN,
	input  logic [31:0]    inst,
	input  logic [31:0]    readData,
	output logic [31:0]    pc,
	output logic [31:0]    dataAddr,
	output logic [31:0]    writeData,
	output logic           memWrite,
	output rvPkg::memSizeE memSize,
	output logic           halted
);

	rvPkg::ctrlT ctrl;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [4:0]  rd;
	logic [31:0] imm;
	logic [31:0] rs1Data;
	logic [31:0] rs2Data;
	logic [31:0] aluResult;
	logic [31:0] pcPlus4;
	logic [31:0] rdData;
	logic        regWe;

	rvDecoder decoder_i (
		.inst (inst),
		.ctrl (ctrl),
		.rs1  (rs1),
		.rs2  (rs2),
		.rd   (rd),
		.imm  (imm)
	);

	// no writes once halted
	assign regWe = ctrl.regWrite & ~halted & (rd != 5'd0);

	rvRegFile regFile_i (
		.clk     (clk),
		.arstN   (arstN),
		.rs1     (rs1),
		.rs2     (rs2),
		.rd      (rd),
		.rdData  (rdData),
		.we      (regWe),
		.rs1Data (rs1Data),
		.rs2Data (rs2Data)
	);

	rvAlu alu_i (
		.ctrl      (ctrl),
		.pc        (pc),
		.rs1Data   (rs1Data),
		.rs2Data   (rs2Data),
		.imm       (imm),
		.aluResult (aluResult)
	);

	rvPcUnit pcUnit_i (
		.clk     (clk),
		.arstN   (arstN),
		.ctrl    (ctrl),
		.rs1Data (rs1Data),
		.rs2Data (rs2Data),
		.imm     (imm),
		.pc      (pc),
		.pcPlus4 (pcPlus4),
		.halted  (halted)
	);

	rvWriteback writeback_i (
		.ctrl      (ctrl),
		.aluResult (aluResult),
		.pcPlus4   (pcPlus4),
		.readData  (readData),
		.rdData    (rdData)
	);

	assign dataAddr = aluResult;
	assign memSize  = ctrl.memSize;
	assign memWrite = ctrl.memWrite & ~halted;

	// copy the store data into every lane it may land in
	always_comb begin
		case (ctrl.memSize)
			rvPkg::memByte: writeData = {4{rs2Data[7:0]}};
			rvPkg::memHalf: writeData = {2{rs2Data[15:0]}};
			default:        writeData = rs2Data;
		endcase
	end

endmodule

//--- hdl/rvDecoder.sv
`timescale 1ns/10ps

module rvDecoder (
	input  logic [31:0] inst,
	output rvPkg::ctrlT ctrl,
	output logic [4:0]  rs1,
	output logic [4:0]  rs2,
	output logic [4:0]  rd,
	output logic [31:0] imm
);

	rvPkg::opcodeE opcode;
	logic [2:0]    funct3;
	logic          funct7b5;
	logic [31:0]   immI;
	logic [31:0]   immS;
	logic [31:0]   immB;
	logic [31:0]   immU;
	logic [31:0]   immJ;

	function automatic rvPkg::aluOpE aluFromFunct(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: aluFromFunct = alt ? rvPkg::aluSub : rvPkg::aluAdd;
			3'b001: aluFromFunct = rvPkg::aluSll;
			3'b010: aluFromFunct = rvPkg::aluSlt;
			3'b011: aluFromFunct = rvPkg::aluSltu;
			3'b100: aluFromFunct = rvPkg::aluXor;
			3'b101: aluFromFunct = alt ? rvPkg::aluSra : rvPkg::aluSrl;
			3'b110: aluFromFunct = rvPkg::aluOr;
			default: aluFromFunct = rvPkg::aluAnd;
		endcase
	endfunction

	assign opcode   = rvPkg::opcodeE'(inst[6:0]);
	assign funct3   = inst[14:12];
	assign funct7b5 = inst[30];
	assign rd       = inst[11:7];
	assign rs1      = inst[19:15];
	assign rs2      = inst[24:20];

	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immU = {inst[31:12], 12'b0};
	assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		// defaults give a nop with no writes
		ctrl.aluOp        = rvPkg::aluAdd;
		ctrl.aluAPc       = 1'b0;
		ctrl.aluAZero     = 1'b0;
		ctrl.aluBImm      = 1'b0;
		ctrl.regWrite     = 1'b0;
		ctrl.memWrite     = 1'b0;
		ctrl.memRead      = 1'b0;
		ctrl.memSize      = rvPkg::memWord;
		ctrl.loadUnsigned = 1'b0;
		ctrl.wbSel        = rvPkg::wbAlu;
		ctrl.pcSel        = rvPkg::selPlus4;
		ctrl.branchCond   = rvPkg::brEq;
		ctrl.halt         = 1'b0;
		imm               = immI;
		case (opcode)
			rvPkg::opcLui: begin
				ctrl.aluAZero = 1'b1;
				ctrl.aluBImm  = 1'b1;
				ctrl.regWrite = 1'b1;
				imm           = immU;
			end
			rvPkg::opcAuipc: begin
				ctrl.aluAPc   = 1'b1;
				ctrl.aluBImm  = 1'b1;
				ctrl.regWrite = 1'b1;
				imm           = immU;
			end
			rvPkg::opcJal: begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSel    = rvPkg::wbLink;
				ctrl.pcSel    = rvPkg::selJal;
				imm           = immJ;
			end
			rvPkg::opcJalr: begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSel    = rvPkg::wbLink;
				ctrl.pcSel    = rvPkg::selJalr;
			end
			rvPkg::opcBranch: begin
				if (funct3 != 3'b010 && funct3 != 3'b011) begin
					ctrl.pcSel      = rvPkg::selBranch;
					ctrl.branchCond = rvPkg::branchCondE'(funct3);
				end
				imm = immB;
			end
			rvPkg::opcLoad: begin
				if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
					ctrl.aluBImm      = 1'b1;
					ctrl.regWrite     = 1'b1;
					ctrl.memRead      = 1'b1;
					ctrl.memSize      = rvPkg::memSizeE'(funct3[1:0]);
					ctrl.loadUnsigned = funct3[2];
					ctrl.wbSel        = rvPkg::wbMem;
				end
			end
			rvPkg::opcStore: begin
				if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
					ctrl.aluBImm  = 1'b1;
					ctrl.memWrite = 1'b1;
					ctrl.memSize  = rvPkg::memSizeE'(funct3[1:0]);
				end
				imm = immS;
			end
			rvPkg::opcOpImm: begin
				// bit 30 only selects sra for immediates
				ctrl.aluOp    = aluFromFunct(funct3, funct3 == 3'b101 && funct7b5);
				ctrl.aluBImm  = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			rvPkg::opcOp: begin
				ctrl.aluOp    = aluFromFunct(funct3, funct7b5);
				ctrl.regWrite = 1'b1;
			end
			rvPkg::opcSystem: begin
				ctrl.halt = (inst == rvPkg::ebreakInst);
			end
			default: begin
			end
		endcase
	end

endmodule

//--- hdl/rvPcUnit.sv
`timescale 1ns/10ps

module rvPcUnit (
	input  logic        clk,
	input  logic        arstN,
	input  rvPkg::ctrlT ctrl,
	input  logic [31:0] rs1Data,
	input  logic [31:0] rs2Data,
	input  logic [31:0] imm,
	output logic [31:0] pc,
	output logic [31:0] pcPlus4,
	output logic        halted
);

	logic        taken;
	logic [31:0] pcRel;
	logic [31:0] jalrTarget;
	logic [31:0] pcNext;

	always_comb begin
		case (ctrl.branchCond)
			rvPkg::brEq:  taken = (rs1Data == rs2Data);
			rvPkg::brNe:  taken = (rs1Data != rs2Data);
			rvPkg::brLt:  taken = ($signed(rs1Data) < $signed(rs2Data));
			rvPkg::brGe:  taken = ($signed(rs1Data) >= $signed(rs2Data));
			rvPkg::brLtu: taken = (rs1Data < rs2Data);
			rvPkg::brGeu: taken = (rs1Data >= rs2Data);
			default:      taken = 1'b0;
		endcase
	end

	assign pcPlus4    = pc + 32'd4;
	assign pcRel      = pc + imm;
	assign jalrTarget = (rs1Data + imm) & ~32'd1;

	always_comb begin
		case (ctrl.pcSel)
			rvPkg::selBranch: pcNext = taken ? pcRel : pcPlus4;
			rvPkg::selJal:    pcNext = pcRel;
			rvPkg::selJalr:   pcNext = jalrTarget;
			default:          pcNext = pcPlus4;
		endcase
	end

	// ebreak keeps its own address and the core stays there
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc     <= rvPkg::resetPc;
			halted <= 1'b0;
		end else if (!halted) begin
			if (ctrl.halt) begin
				halted <= 1'b1;
			end else begin
				pc <= pcNext;
			end
		end
	end

endmodule

//--- hdl/rvPkg.sv
package rvPkg;

	localparam int xlen = 32;
	localparam logic [xlen-1:0] resetPc = 32'h0000_0000;

	// full encoding of ebreak, funct12 = 1
	localparam logic [31:0] ebreakInst = 32'h0010_0073;

	typedef enum logic [6:0] {
		opcLui    = 7'b0110111,
		opcAuipc  = 7'b0010111,
		opcJal    = 7'b1101111,
		opcJalr   = 7'b1100111,
		opcBranch = 7'b1100011,
		opcLoad   = 7'b0000011,
		opcStore  = 7'b0100011,
		opcOpImm  = 7'b0010011,
		opcOp     = 7'b0110011,
		opcSystem = 7'b1110011
	} opcodeE;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd,
		aluPassB
	} aluOpE;

	// values follow branch funct3
	typedef enum logic [2:0] {
		brEq  = 3'b000,
		brNe  = 3'b001,
		brLt  = 3'b100,
		brGe  = 3'b101,
		brLtu = 3'b110,
		brGeu = 3'b111
	} branchCondE;

	typedef enum logic [1:0] {
		selPlus4,
		selBranch,
		selJal,
		selJalr
	} pcSelE;

	typedef enum logic [1:0] {
		wbAlu,
		wbMem,
		wbLink
	} wbSelE;

	// values follow load/store funct3[1:0]
	typedef enum logic [1:0] {
		memByte = 2'b00,
		memHalf = 2'b01,
		memWord = 2'b10
	} memSizeE;

	typedef struct packed {
		aluOpE      aluOp;
		logic       aluAPc;
		logic       aluAZero;
		logic       aluBImm;
		logic       regWrite;
		logic       memWrite;
		logic       memRead;
		memSizeE    memSize;
		logic       loadUnsigned;
		wbSelE      wbSel;
		pcSelE      pcSel;
		branchCondE branchCond;
		logic       halt;
	} ctrlT;

endpackage

//--- hdl/rvRegFile.sv
`timescale 1ns/10ps

module rvRegFile (
	input  logic        clk,
	input  logic        arstN,
	input  logic [4:0]  rs1,
	input  logic [4:0]  rs2,
	input  logic [4:0]  rd,
	input  logic [31:0] rdData,
	input  logic        we,
	output logic [31:0] rs1Data,
	output logic [31:0] rs2Data
);

	// x0 has no storage
	logic [rvPkg::xlen-1:0] regs [1:31];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != 5'd0) begin
			regs[rd] <= rdData;
		end
	end

	assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- hdl/rvWriteback.sv
`timescale 1ns/10ps

module rvWriteback (
	input  rvPkg::ctrlT ctrl,
	input  logic [31:0] aluResult,
	input  logic [31:0] pcPlus4,
	input  logic [31:0] readData,
	output logic [31:0] rdData
);

	logic [7:0]  loadByte;
	logic [15:0] loadHalf;
	logic [31:0] loadVal;

	// lane select from the low address bits
	assign loadByte = readData[8*aluResult[1:0] +: 8];
	assign loadHalf = aluResult[1] ? readData[31:16] : readData[15:0];

	always_comb begin
		loadVal = '0;
		if (ctrl.memRead) begin
			case (ctrl.memSize)
				rvPkg::memByte: begin
					loadVal = {{24{~ctrl.loadUnsigned & loadByte[7]}}, loadByte};
				end
				rvPkg::memHalf: begin
					loadVal = {{16{~ctrl.loadUnsigned & loadHalf[15]}}, loadHalf};
				end
				default: begin
					loadVal = readData;
				end
			endcase
		end
	end

	always_comb begin
		case (ctrl.wbSel)
			rvPkg::wbMem:  rdData = loadVal;
			rvPkg::wbLink: rdData = pcPlus4;
			default:       rdData = aluResult;
		endcase
	end

endmodule

//--- project.f
hdl/rvPkg.sv
hdl/rvDecoder.sv
hdl/rvRegFile.sv
hdl/rvAlu.sv
hdl/rvPcUnit.sv
hdl/rvWriteback.sv
hdl/rvCore.sv
dv/rvCoreTb.sv
